// ==== hw/aluUnit.sv ====
`timescale 1ns/1ps

module aluUnit import rvExecPkg::*; (
  input  logic [aluOpBits-1:0] aluOp,
  input  logic [xlen-1:0]      operandA,
  input  logic [xlen-1:0]      operandB,
  output logic [xlen-1:0]      result,
  output logic                 conditionMet
);

  logic [xlen-1:0] difference;
  logic            equal;
  logic            lessSigned;
  logic            lessUnsigned;

  // shared compare terms, used by slt and by the branches
  assign difference = operandA - operandB;
  assign equal = (operandA == operandB);
  assign lessSigned = ($signed(operandA) < $signed(operandB));
  assign lessUnsigned = (operandA < operandB);

  // arithmetic and logic result
  always_comb
  begin
    case (aluOp)
      aluAdd: result = operandA + operandB;
      aluSub: result = difference;
      aluXor: result = operandA ^ operandB;
      aluOr: result = operandA | operandB;
      aluAnd: result = operandA & operandB;
      aluSlt: result = {{(xlen-1){1'b0}}, lessSigned};
      aluSltu: result = {{(xlen-1){1'b0}}, lessUnsigned};
      // lui arrives here with the upper immediate on b
      aluPassB: result = operandB;
      default: result = '0;
    endcase
  end

  // branch condition, zero for anything that is not a branch
  always_comb
  begin
    case (aluOp)
      aluEq: conditionMet = equal;
      aluNe: conditionMet = !equal;
      aluLt: conditionMet = lessSigned;
      aluGe: conditionMet = !lessSigned;
      aluLtu: conditionMet = lessUnsigned;
      aluGeu: conditionMet = !lessUnsigned;
      default: conditionMet = 1'b0;
    endcase
  end

endmodule

// ==== hw/dataMemory.sv ====
`timescale 1ns/1ps

module dataMemory import rvExecPkg::*; (
  input  logic                   clock,
  input  logic                   writeEnable,
  input  logic [memAddrBits-1:0] address,
  input  logic [xlen-1:0]        writeData,
  output logic [xlen-1:0]        readData
);

  // word array, contents undefined until stored
  logic [xlen-1:0] mem [memWords];

  // asynchronous read port
  assign readData = mem[address];

  // single write port on the rising edge
  always_ff @(posedge clock)
  begin
    if (writeEnable)
      mem[address] <= writeData;
  end

  // a store must never land on an unknown word
  addrKnownOnWrite: assert property (@(posedge clock)
    writeEnable |-> !$isunknown(address));

endmodule

// ==== hw/execControl.sv ====
`timescale 1ns/1ps

module execControl (
  input  logic clock,
  input  logic reset,
  input  logic instrValid,
  input  logic isShift,
  input  logic isLoad,
  input  logic isStore,
  input  logic writesReg,
  input  logic shiftDone,
  output logic latchInstr,
  output logic shiftStart,
  output logic memWrite,
  output logic regWrite,
  output logic busy,
  output logic done
);

  typedef enum logic [2:0] {
    stateIdle,
    stateRead,
    stateExec,
    stateMem,
    stateWrite
  } stateT;

  stateT state;
  stateT nextState;
  // high in the first exec cycle only
  logic  execEntry;

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      state <= stateIdle;
      execEntry <= 1'b0;
    end
    else
    begin
      state <= nextState;
      execEntry <= (state == stateRead);
    end
  end

  // read waits out the registered register file
  always_comb
  begin
    nextState = state;
    case (state)
      stateIdle:
      begin
        if (instrValid)
          nextState = stateRead;
      end
      stateRead: nextState = stateExec;
      stateExec:
      begin
        // shifter holds exec until it reports done
        if (isShift)
        begin
          if (shiftDone)
            nextState = stateWrite;
        end
        else if (isLoad)
          nextState = stateMem;
        else
          nextState = stateWrite;
      end
      stateMem: nextState = stateWrite;
      stateWrite: nextState = stateIdle;
      default: nextState = stateIdle;
    endcase
  end

  // strobes while busy are dropped here
  assign latchInstr = (state == stateIdle) && instrValid;
  assign shiftStart = (state == stateExec) && execEntry && isShift;
  // stores write in exec, loads read through mem
  assign memWrite = (state == stateExec) && isStore;
  assign regWrite = (state == stateWrite) && writesReg;
  assign done = (state == stateWrite);
  assign busy = (state != stateIdle);

  donePulse: assert property (@(posedge clock) disable iff (!reset)
    done |=> !done);

  // one instruction writes memory or a register, never both
  writeExclusive: assert property (@(posedge clock) disable iff (!reset)
    busy |-> !(isStore && writesReg));

endmodule

// ==== hw/execCore.sv ====
`timescale 1ns/1ps

module execCore import rvExecPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   instrValid,
  input  logic [xlen-1:0]        instr,
  output logic                   busy,
  output logic                   done,
  output logic                   wbEnable,
  output logic [regAddrBits-1:0] wbAddr,
  output logic [xlen-1:0]        wbData,
  output logic                   branchTaken
);

  logic [xlen-1:0]          instrReg;
  logic                     latchInstr;
  logic                     shiftStart;
  logic                     shiftDone;
  logic                     memWrite;
  logic                     regWrite;
  logic [aluOpBits-1:0]     aluOp;
  logic [xlen-1:0]          immediate;
  logic                     useImmediate;
  logic                     isShift;
  logic [shiftKindBits-1:0] shiftKind;
  logic                     isLoad;
  logic                     isStore;
  logic                     isBranch;
  logic                     writesReg;
  logic [regAddrBits-1:0]   rs1;
  logic [regAddrBits-1:0]   rs2;
  logic [regAddrBits-1:0]   rd;
  logic [xlen-1:0]          readDataA;
  logic [xlen-1:0]          readDataB;
  logic [xlen-1:0]          operandB;
  logic [xlen-1:0]          aluResult;
  logic                     conditionMet;
  logic [xlen-1:0]          shiftOut;
  logic [xlen-1:0]          memReadData;

  // instruction held for the whole operation
  always_ff @(posedge clock)
  begin
    if (latchInstr)
      instrReg <= instr;
  end

  // sampled in exec, shown in the done cycle
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
      branchTaken <= 1'b0;
    else
      branchTaken <= isBranch && conditionMet;
  end

  // operand b also carries the shift amount
  assign operandB = useImmediate ? immediate : readDataB;
  assign wbData = isLoad ? memReadData : isShift ? shiftOut : aluResult;
  assign wbEnable = regWrite;
  assign wbAddr = rd;

  execControl control (.clock, .reset, .instrValid, .isShift, .isLoad, .isStore, .writesReg,
    .shiftDone, .latchInstr, .shiftStart, .memWrite, .regWrite, .busy, .done);

  instrDecoder decoder (.instr(instrReg), .aluOp, .immediate, .useImmediate, .isShift,
    .shiftKind, .isLoad, .isStore, .isBranch, .writesReg, .rs1, .rs2, .rd);

  regFile registers (.clock, .reset, .readAddrA(rs1), .readAddrB(rs2), .writeAddr(rd),
    .writeEnable(regWrite), .writeData(wbData), .readDataA, .readDataB);

  aluUnit alu (.aluOp, .operandA(readDataA), .operandB, .result(aluResult), .conditionMet);

  shiftSequencer shifter (.clock, .reset, .shiftStart, .shiftKind, .shiftIn(readDataA),
    .shiftAmount(operandB[shamtBits-1:0]), .shiftOut, .shiftDone);

  // byte address from the alu, dropped to a word index
  dataMemory memory (.clock, .writeEnable(memWrite), .address(aluResult[memAddrBits+1:2]),
    .writeData(readDataB), .readData(memReadData));

endmodule

// ==== hw/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import rvExecPkg::*; (
  input  logic [xlen-1:0]          instr,
  output logic [aluOpBits-1:0]     aluOp,
  output logic [xlen-1:0]          immediate,
  output logic                     useImmediate,
  output logic                     isShift,
  output logic [shiftKindBits-1:0] shiftKind,
  output logic                     isLoad,
  output logic                     isStore,
  output logic                     isBranch,
  output logic                     writesReg,
  output logic [regAddrBits-1:0]   rs1,
  output logic [regAddrBits-1:0]   rs2,
  output logic [regAddrBits-1:0]   rd
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            altFunct;
  logic            isRType;
  logic            isIType;
  logic            isLui;
  logic [xlen-1:0] immI;
  logic [xlen-1:0] immS;
  logic [xlen-1:0] immB;
  logic [xlen-1:0] immU;

  // fixed instruction fields
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign altFunct = instr[funct7AltBit];
  assign rd = instr[11:7];
  assign rs1 = instr[19:15];
  assign rs2 = instr[24:20];

  // sign-extended immediates, b is already in bytes
  assign immI = {{20{instr[31]}}, instr[31:20]};
  assign immS = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign immB = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign immU = {instr[31:12], 12'b0};

  // instruction class
  assign isRType = (opcode == opcodeRType);
  assign isIType = (opcode == opcodeIType);
  assign isLui = (opcode == opcodeLui);
  assign isLoad = (opcode == opcodeLoad);
  assign isStore = (opcode == opcodeStore);
  assign isBranch = (opcode == opcodeBranch);
  assign isShift = (isRType || isIType) && (funct3 == f3Sll || funct3 == f3Srl);
  assign writesReg = isRType || isIType || isLoad || isLui;
  // only r-type and branches compare two registers
  assign useImmediate = !(isRType || isBranch);

  // srai and slli keep funct7 in the immediate, so altFunct works for both forms
  assign shiftKind = (funct3 == f3Sll) ? shiftLeft :
                     altFunct ? shiftRightArith : shiftRightLogic;

  always_comb
  begin
    case (opcode)
      opcodeStore: immediate = immS;
      opcodeBranch: immediate = immB;
      opcodeLui: immediate = immU;
      default: immediate = immI;
    endcase
  end

  // loads, stores and shifts fall through to add
  always_comb
  begin
    aluOp = aluAdd;
    if (isBranch)
    begin
      case (funct3)
        f3Beq: aluOp = aluEq;
        f3Bne: aluOp = aluNe;
        f3Blt: aluOp = aluLt;
        f3Bge: aluOp = aluGe;
        f3Bltu: aluOp = aluLtu;
        f3Bgeu: aluOp = aluGeu;
        default: aluOp = aluAdd;
      endcase
    end
    else if (isLui)
      aluOp = aluPassB;
    else if (isRType || isIType)
    begin
      case (funct3)
        // addi has no sub form
        f3AddSub: aluOp = (isRType && altFunct) ? aluSub : aluAdd;
        f3Xor: aluOp = aluXor;
        f3Or: aluOp = aluOr;
        f3And: aluOp = aluAnd;
        f3Slt: aluOp = aluSlt;
        f3Sltu: aluOp = aluSltu;
        default: aluOp = aluAdd;
      endcase
    end
  end

endmodule

// ==== hw/regFile.sv ====
`timescale 1ns/1ps

module regFile import rvExecPkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [regAddrBits-1:0] readAddrA,
  input  logic [regAddrBits-1:0] readAddrB,
  input  logic [regAddrBits-1:0] writeAddr,
  input  logic                   writeEnable,
  input  logic [xlen-1:0]        writeData,
  output logic [xlen-1:0]        readDataA,
  output logic [xlen-1:0]        readDataB
);

  logic [xlen-1:0] regs [regCount];
  logic            writeValid;

  // x0 is never written
  assign writeValid = writeEnable && (writeAddr != '0);

  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      // register i starts out holding i, so x0 starts at zero
      for (int i = 0; i < regCount; i++)
        regs[i] <= xlen'(i);
      readDataA <= '0;
      readDataB <= '0;
    end
    else
    begin
      // registered reads, a same-cycle write wins over the array
      readDataA <= (writeValid && writeAddr == readAddrA) ? writeData : regs[readAddrA];
      readDataB <= (writeValid && writeAddr == readAddrB) ? writeData : regs[readAddrB];
      if (writeValid)
        regs[writeAddr] <= writeData;
    end
  end

  // x0 reads back zero even right after a write to it
  zeroReadA: assert property (@(posedge clock) disable iff (!reset)
    readAddrA == '0 |=> readDataA == '0);
  zeroReadB: assert property (@(posedge clock) disable iff (!reset)
    readAddrB == '0 |=> readDataB == '0);

endmodule

// ==== hw/rvExecPkg.sv ====
package rvExecPkg;

  // datapath and register file widths
  localparam int xlen = 32;
  localparam int regAddrBits = 5;
  localparam int regCount = 1 << regAddrBits;

  // data memory holds 1024 words, addressed by word
  localparam int memAddrBits = 10;
  localparam int memWords = 1 << memAddrBits;

  // shift amount is the low five bits of operand b
  localparam int shamtBits = 5;

  // major opcodes of the supported subset
  localparam logic [6:0] opcodeRType = 7'b0110011;
  localparam logic [6:0] opcodeIType = 7'b0010011;
  localparam logic [6:0] opcodeLoad = 7'b0000011;
  localparam logic [6:0] opcodeStore = 7'b0100011;
  localparam logic [6:0] opcodeBranch = 7'b1100011;
  localparam logic [6:0] opcodeLui = 7'b0110111;

  // funct3 for register and immediate arithmetic
  localparam logic [2:0] f3AddSub = 3'b000;
  localparam logic [2:0] f3Sll = 3'b001;
  localparam logic [2:0] f3Slt = 3'b010;
  localparam logic [2:0] f3Sltu = 3'b011;
  localparam logic [2:0] f3Xor = 3'b100;
  localparam logic [2:0] f3Srl = 3'b101;
  localparam logic [2:0] f3Or = 3'b110;
  localparam logic [2:0] f3And = 3'b111;

  // funct3 for branches
  localparam logic [2:0] f3Beq = 3'b000;
  localparam logic [2:0] f3Bne = 3'b001;
  localparam logic [2:0] f3Blt = 3'b100;
  localparam logic [2:0] f3Bge = 3'b101;
  localparam logic [2:0] f3Bltu = 3'b110;
  localparam logic [2:0] f3Bgeu = 3'b111;

  // funct7 bit that selects sub and sra
  localparam int funct7AltBit = 30;

  // alu operation codes, branch conditions in the upper half
  localparam int aluOpBits = 4;
  localparam logic [aluOpBits-1:0] aluAdd = 4'd0;
  localparam logic [aluOpBits-1:0] aluSub = 4'd1;
  localparam logic [aluOpBits-1:0] aluXor = 4'd2;
  localparam logic [aluOpBits-1:0] aluOr = 4'd3;
  localparam logic [aluOpBits-1:0] aluAnd = 4'd4;
  localparam logic [aluOpBits-1:0] aluSlt = 4'd5;
  localparam logic [aluOpBits-1:0] aluSltu = 4'd6;
  localparam logic [aluOpBits-1:0] aluPassB = 4'd7;
  localparam logic [aluOpBits-1:0] aluEq = 4'd8;
  localparam logic [aluOpBits-1:0] aluNe = 4'd9;
  localparam logic [aluOpBits-1:0] aluLt = 4'd10;
  localparam logic [aluOpBits-1:0] aluGe = 4'd11;
  localparam logic [aluOpBits-1:0] aluLtu = 4'd12;
  localparam logic [aluOpBits-1:0] aluGeu = 4'd13;

  // serial shifter direction
  localparam int shiftKindBits = 2;
  localparam logic [shiftKindBits-1:0] shiftLeft = 2'd0;
  localparam logic [shiftKindBits-1:0] shiftRightLogic = 2'd1;
  localparam logic [shiftKindBits-1:0] shiftRightArith = 2'd2;

endpackage

// ==== hw/shiftSequencer.sv ====
`timescale 1ns/1ps

module shiftSequencer import rvExecPkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     shiftStart,
  input  logic [shiftKindBits-1:0] shiftKind,
  input  logic [xlen-1:0]          shiftIn,
  input  logic [shamtBits-1:0]     shiftAmount,
  output logic [xlen-1:0]          shiftOut,
  output logic                     shiftDone
);

  logic [xlen-1:0]      dataReg;
  logic [shamtBits-1:0] count;

  // one place in the requested direction
  function automatic logic [xlen-1:0] shiftOnce(input logic [xlen-1:0] value,
                                                input logic [shiftKindBits-1:0] kind);
    logic [xlen-1:0] shifted;
    case (kind)
      shiftLeft: shifted = {value[xlen-2:0], 1'b0};
      shiftRightLogic: shifted = {1'b0, value[xlen-1:1]};
      shiftRightArith: shifted = {value[xlen-1], value[xlen-1:1]};
      default: shifted = value;
    endcase
    return shifted;
  endfunction

  // first step happens on the load edge, so count holds the steps left
  always_ff @(posedge clock)
  begin
    if (shiftStart)
      dataReg <= (shiftAmount != '0) ? shiftOnce(shiftIn, shiftKind) : shiftIn;
    else if (count != '0)
      dataReg <= shiftOnce(dataReg, shiftKind);
  end

  // down-counter and done pulse
  always_ff @(posedge clock or negedge reset)
  begin
    if (!reset)
    begin
      count <= '0;
      shiftDone <= 1'b0;
    end
    else if (shiftStart)
    begin
      count <= (shiftAmount != '0) ? shiftAmount - 1'b1 : '0;
      // zero or one place finishes right after the start
      shiftDone <= (shiftAmount <= shamtBits'(1));
    end
    else if (count != '0)
    begin
      count <= count - 1'b1;
      shiftDone <= (count == shamtBits'(1));
    end
    else
      shiftDone <= 1'b0;
  end

  assign shiftOut = dataReg;

  // a restart while steps remain would cut the running shift short
  noStartWhileCounting: assert property (@(posedge clock) disable iff (!reset)
    count != '0 |-> !shiftStart);

  // control never restarts the shifter in the done cycle
  doneSinglePulse: assert property (@(posedge clock) disable iff (!reset)
    shiftDone |=> !shiftDone);

endmodule

// ==== run.sh ====
#!/bin/sh
# build the execCore testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module execCoreTb \
  -f vlog.f -o execCoreSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOutput=$(./obj_dir/execCoreSim)
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOutput" | grep -qx 'STATUS: PASS'; then
  exit 0
fi
exit 1

// ==== tests/execCases.txt ====
// instr busyInstr wbEnable wbAddr wbData branchTaken, all hex, one case per line
// busyInstr is strobed one cycle after instr while the core is busy, zero for none
// register alu operations on the reset values
00418533 00000000 1 0a 00000007 0  // add x10, x3, x4
405185b3 00000000 1 0b fffffffe 0  // sub x11, x3, x5
00734633 00000000 1 0c 00000001 0  // xor x12, x6, x7
0064e6b3 00000000 1 0d 0000000f 0  // or x13, x9, x6
0077f733 00000000 1 0e 00000007 0  // and x14, x15, x7
0025a833 00000000 1 10 00000001 0  // slt x16, x11, x2
0025b8b3 00000000 1 11 00000000 0  // sltu x17, x11, x2
// immediate alu operations
ffa28913 00000000 1 12 ffffffff 0  // addi x18, x5, -6
0f044993 00000000 1 13 000000f8 0  // xori x19, x8, 0xf0
f000ea13 00000000 1 14 ffffff01 0  // ori x20, x1, -256
7fc6fa93 00000000 1 15 0000000c 0  // andi x21, x13, 0x7fc
00092b13 00000000 1 16 00000001 0  // slti x22, x18, 0
fff2bb93 00000000 1 17 00000001 0  // sltiu x23, x5, -1
00548013 00000000 1 00 0000000e 0  // addi x0, x9, 5
00300c33 00000000 1 18 00000003 0  // add x24, x0, x3
// shifts by 0, 1 and 31
00099cb3 00000000 1 19 000000f8 0  // sll x25, x19, x0
00199d13 00000000 1 1a 000001f0 0  // slli x26, x19, 1
01f09db3 00000000 1 1b 80000000 0  // sll x27, x1, x31
001a5e33 00000000 1 1c 7fffff80 0  // srl x28, x20, x1
01fa5e93 00000000 1 1d 00000001 0  // srli x29, x20, 31
000a5f13 00000000 1 1e ffffff01 0  // srli x30, x20, 0
400a5cb3 00000000 1 19 ffffff01 0  // sra x25, x20, x0
401a5d13 00000000 1 1a ffffff80 0  // srai x26, x20, 1
41fa5db3 00000000 1 1b ffffffff 0  // sra x27, x20, x31
// store then load of word 5
01422823 00000000 0 00 00000000 0  // sw x20, 16(x4)
01402483 00000000 1 09 ffffff01 0  // lw x9, 20(x0)
// branches, x11 holds -2
00318463 00000000 0 00 00000000 1  // beq x3, x3
00418463 00000000 0 00 00000000 0  // beq x3, x4
00529463 00000000 0 00 00000000 0  // bne x5, x5
00321463 00000000 0 00 00000000 1  // bne x4, x3
0025c463 00000000 0 00 00000000 1  // blt x11, x2
0052c463 00000000 0 00 00000000 0  // blt x5, x5
0052d463 00000000 0 00 00000000 1  // bge x5, x5
0025d463 00000000 0 00 00000000 0  // bge x11, x2
00b16463 00000000 0 00 00000000 1  // bltu x2, x11
0025e463 00000000 0 00 00000000 0  // bltu x11, x2
0025f463 00000000 0 00 00000000 1  // bgeu x11, x2
00b17463 00000000 0 00 00000000 0  // bgeu x2, x11
// back to back dependencies
12345337 00000000 1 06 12345000 0  // lui x6, 0x12345
67830393 00000000 1 07 12345678 0  // addi x7, x6, 0x678
00a50533 00000000 1 0a 0000000e 0  // add x10, x10, x10
// second strobe while busy is dropped, x13 stays 0xf
06418613 00100693 1 0c 00000067 0  // addi x12, x3, 100 then addi x13, x0, 1
00068713 00000000 1 0e 0000000f 0  // addi x14, x13, 0

// ==== tests/execCoreTb.sv ====
`timescale 1ns/1ps

module execCoreTb import rvExecPkg::*; ();

  localparam int caseFields = 6;
  localparam int maxCases = 64;
  localparam int doneTimeout = 50;
  localparam int quietCycles = 10;
  localparam int randomCount = 16;

  logic                   clock;
  logic                   reset;
  logic                   instrValid;
  logic [xlen-1:0]        instr;
  logic                   busy;
  logic                   done;
  logic                   wbEnable;
  logic [regAddrBits-1:0] wbAddr;
  logic [xlen-1:0]        wbData;
  logic                   branchTaken;

  // six words per case, see the header of the cases file
  logic [31:0]     caseMem [caseFields*maxCases];
  // expected register contents for the random addi phase
  logic [xlen-1:0] regModel [regCount];
  int              mismatchCount;
  int              timeoutCount;
  int              protocolCount;
  int              seed;
  logic            timedOut;

  execCore DUT (.clock, .reset, .instrValid, .instr, .busy, .done, .wbEnable, .wbAddr,
    .wbData, .branchTaken);

  // 40 ns period
  always
  begin
    #20 clock = ~clock;
  end

  // strobe one instruction, and optionally a second one while the core is busy
  task automatic issue(input logic [xlen-1:0] word, input logic [xlen-1:0] busyWord);
    @(posedge clock);
    instr <= word;
    instrValid <= 1'b1;
    @(posedge clock);
    if (busyWord != '0)
    begin
      // core sits in read now
      instr <= busyWord;
      @(posedge clock);
    end
    instrValid <= 1'b0;
  endtask

  // outputs are sampled on the falling edge
  task automatic waitForDone(output logic seen);
    int cycles;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < doneTimeout)
    begin
      @(negedge clock);
      if (done)
        seen = 1'b1;
      cycles++;
    end
  endtask

  task automatic reportTimeout(input logic [xlen-1:0] word);
    $display("timeout: instruction %h got no done within %0d cycles", word, doneTimeout);
    timeoutCount++;
    timedOut = 1'b1;
  endtask

  // address and data only matter when a register is written
  task automatic checkWriteback(input logic expEnable, input logic [regAddrBits-1:0] expAddr,
                                input logic [xlen-1:0] expData, input logic expBranch);
    assert (wbEnable === expEnable)
    else
    begin
      $display("FAILED t=%0t wbEnable expected %b got %b", $time, expEnable, wbEnable);
      mismatchCount++;
    end
    if (expEnable)
    begin
      assert (wbAddr === expAddr)
      else
      begin
        $display("FAILED t=%0t wbAddr expected %0d got %0d", $time, expAddr, wbAddr);
        mismatchCount++;
      end
      assert (wbData === expData)
      else
      begin
        $display("FAILED t=%0t wbData expected %h got %h", $time, expData, wbData);
        mismatchCount++;
      end
    end
    assert (branchTaken === expBranch)
    else
    begin
      $display("FAILED t=%0t branchTaken expected %b got %b", $time, expBranch, branchTaken);
      mismatchCount++;
    end
  endtask

  // a dropped strobe must not start a second operation
  task automatic checkSingleDone(input logic [xlen-1:0] word);
    int extraDones;
    extraDones = 0;
    for (int n = 0; n < quietCycles; n++)
    begin
      @(negedge clock);
      if (done)
        extraDones++;
    end
    assert (extraDones == 0)
    else
    begin
      $display("a strobe sent while busy with %h started a second operation", word);
      protocolCount++;
    end
  endtask

  task automatic runFileCase(input int index);
    int              base;
    logic [xlen-1:0] word;
    logic [xlen-1:0] busyWord;
    logic            seen;
    base = index * caseFields;
    word = caseMem[base];
    busyWord = caseMem[base+1];
    issue(word, busyWord);
    waitForDone(seen);
    assert (seen) else reportTimeout(word);
    if (seen)
    begin
      checkWriteback(caseMem[base+2][0], caseMem[base+3][regAddrBits-1:0], caseMem[base+4],
                     caseMem[base+5][0]);
      if (busyWord != '0)
        checkSingleDone(word);
    end
  endtask

  // random addi chains against a model that starts from the reset contents
  task automatic runRandomAddi();
    logic [xlen-1:0]        word;
    logic [xlen-1:0]        expected;
    logic [11:0]            imm;
    logic [regAddrBits-1:0] rs1;
    logic [regAddrBits-1:0] rd;
    logic                   seen;
    @(posedge clock);
    reset <= 1'b0;
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    for (int i = 0; i < regCount; i++)
      regModel[i] = xlen'(i);
    for (int n = 0; n < randomCount && !timedOut; n++)
    begin
      imm = 12'($random(seed));
      rs1 = 5'($random(seed));
      rd = 5'($random(seed));
      // addi opcode with funct3 zero
      word = {imm, rs1, 3'b000, rd, 7'b0010011};
      expected = regModel[rs1] + {{20{imm[11]}}, imm};
      issue(word, '0);
      waitForDone(seen);
      assert (seen) else reportTimeout(word);
      if (seen)
      begin
        checkWriteback(1'b1, rd, expected, 1'b0);
        // x0 keeps zero in the model too
        if (rd != '0)
          regModel[rd] = expected;
      end
    end
  endtask

  initial
  begin
    int index;
    clock = 1'b0;
    reset = 1'b0;
    instrValid = 1'b0;
    instr = '0;
    mismatchCount = 0;
    timeoutCount = 0;
    protocolCount = 0;
    seed = 39808;
    timedOut = 1'b0;
    // a zero instruction word ends the case list
    for (int i = 0; i < caseFields * maxCases; i++)
      caseMem[i] = '0;
    $readmemh("tests/execCases.txt", caseMem);
    repeat (2) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    assert (!busy && !done)
    else
    begin
      $display("busy or done is high right after reset");
      protocolCount++;
    end
    index = 0;
    while (!timedOut && index < maxCases && caseMem[index*caseFields] != '0)
    begin
      runFileCase(index);
      index++;
    end
    assert (index > 0)
    else
    begin
      $display("no cases were read from the cases file");
      protocolCount++;
    end
    if (!timedOut)
      runRandomAddi();
    $display("errors: %0d mismatches, %0d timeouts, %0d protocol", mismatchCount,
             timeoutCount, protocolCount);
    if (mismatchCount + timeoutCount + protocolCount == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== vlog.f ====
hw/rvExecPkg.sv
hw/aluUnit.sv
hw/shiftSequencer.sv
hw/regFile.sv
hw/dataMemory.sv
hw/instrDecoder.sv
hw/execControl.sv
hw/execCore.sv
tests/execCoreTb.sv
